/* common/mips_pkg.sv */
package mips_pkg;

	typedef logic [31:0] word_t;	// Data word or address
	typedef logic [4:0] reg_idx_t;	// Register index
	typedef logic [5:0] funct_t;	// Opcode or funct field
	typedef logic [25:0] jump_t;	// J-type target field

	typedef logic [3:0] alu_op_t;	// ALU operation
	localparam alu_op_t ALU_ADD = 4'd0;	// Add
	localparam alu_op_t ALU_SUB = 4'd1;	// Subtract
	localparam alu_op_t ALU_AND = 4'd2;	// Bitwise and
	localparam alu_op_t ALU_OR = 4'd4;	// Bitwise or
	localparam alu_op_t ALU_XOR = 4'd5;	// Bitwise xor
	localparam alu_op_t ALU_FUNCT = 4'd6;	// Look at R-type funct
	localparam alu_op_t ALU_GEZ = 4'd7;	// Sign test of operand a
	localparam alu_op_t ALU_LUI = 4'd9;	// Immediate to upper half

	typedef logic [1:0] pc_src_t;	// Next PC source
	localparam pc_src_t PC_BRANCH = 2'd0;	// PC+1+offset when taken
	localparam pc_src_t PC_JUMP = 2'd1;	// Absolute jump field
	localparam pc_src_t PC_REG = 2'd2;	// Value of rs
	localparam pc_src_t PC_SEQ = 2'd3;	// PC+1

	typedef logic [1:0] reg_dst_t;	// Destination register select
	localparam reg_dst_t DST_RT = 2'd0;	// I-type destination
	localparam reg_dst_t DST_RD = 2'd1;	// R-type destination
	localparam reg_dst_t DST_RA = 2'd2;	// Link register

	typedef logic [1:0] wb_src_t;	// Writeback source
	localparam wb_src_t WB_ALU = 2'd0;	// ALU result
	localparam wb_src_t WB_MEM = 2'd1;	// Load data
	localparam wb_src_t WB_LINK = 2'd2;	// Return address PC+1

	localparam reg_idx_t REG_RA = 5'd31;	// Link register index

	typedef struct packed {
		pc_src_t pc_src;	// Next PC choice
		reg_dst_t reg_dst;	// Which field names the destination
		wb_src_t wb_src;	// Data written to the register file
		alu_op_t alu_op;	// ALU operation
		logic alu_imm;	// Second operand is the immediate
		logic mem_we;	// Store enable
		logic reg_we;	// Register write enable
		logic branch_eq;	// Branch when ALU zero equals this
		logic imm_signed;	// Sign extend imm16
		logic mem_byte;	// Byte access instead of word
	} ctrl_t;

endpackage

/* decode/control_unit.sv */
`timescale 1ns/1ns

module control_unit
	import mips_pkg::*;
(
	input word_t instr,	// Instruction word from memory
	output ctrl_t ctrl,	// Decoded control fields
	output reg_idx_t wr_idx	// Final destination register
);

	funct_t opcode;	// Major opcode
	funct_t funct;	// R-type function
	reg_idx_t rt;	// Selects BGEZ or BGEZAL
	reg_idx_t rd;	// R-type destination

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	always_comb
	begin
		// Safe default is a no-op that moves on to PC+1
		ctrl.pc_src = PC_SEQ;
		ctrl.reg_dst = DST_RT;
		ctrl.wb_src = WB_ALU;
		ctrl.alu_op = ALU_ADD;
		ctrl.alu_imm = 1'b0;
		ctrl.mem_we = 1'b0;
		ctrl.reg_we = 1'b0;
		ctrl.branch_eq = 1'b1;
		ctrl.imm_signed = 1'b1;
		ctrl.mem_byte = 1'b0;
		case (opcode)
			6'b000000:	// R-type
			begin
				ctrl.reg_dst = DST_RD;	// Three-register form
				ctrl.alu_op = ALU_FUNCT;	// ALU reads funct itself
				if (funct == 6'b001000)	// JR
				begin
					ctrl.pc_src = PC_REG;	// PC = rs
				end
				else if (funct == 6'b001001)	// JALR
				begin
					ctrl.pc_src = PC_REG;	// PC = rs
					ctrl.wb_src = WB_LINK;	// rd gets PC+1
					ctrl.reg_we = 1'b1;
				end
				else
				begin
					ctrl.reg_we = (funct >= 6'b100000);	// Multiply group writes nothing
				end
			end
			6'b001000, 6'b001001:	// ADDI, ADDIU
			begin
				ctrl.alu_imm = 1'b1;
				ctrl.reg_we = 1'b1;
			end
			6'b001100:	// ANDI
			begin
				ctrl.alu_op = ALU_AND;
				ctrl.alu_imm = 1'b1;
				ctrl.reg_we = 1'b1;
				ctrl.imm_signed = 1'b0;	// Logic ops zero extend
			end
			6'b001101:	// ORI
			begin
				ctrl.alu_op = ALU_OR;
				ctrl.alu_imm = 1'b1;
				ctrl.reg_we = 1'b1;
				ctrl.imm_signed = 1'b0;
			end
			6'b001110:	// XORI
			begin
				ctrl.alu_op = ALU_XOR;
				ctrl.alu_imm = 1'b1;
				ctrl.reg_we = 1'b1;
				ctrl.imm_signed = 1'b0;
			end
			6'b001111:	// LUI
			begin
				ctrl.alu_op = ALU_LUI;
				ctrl.alu_imm = 1'b1;
				ctrl.reg_we = 1'b1;
				ctrl.imm_signed = 1'b0;
			end
			6'b000100, 6'b000101:	// BEQ, BNE
			begin
				ctrl.pc_src = PC_BRANCH;
				ctrl.alu_op = ALU_SUB;	// Zero flag means equal
				ctrl.branch_eq = ~opcode[0];	// BNE takes the branch on not zero
			end
			6'b000001:	// REGIMM
			begin
				ctrl.pc_src = PC_BRANCH;
				ctrl.alu_op = ALU_GEZ;	// Zero flag means rs >= 0
				ctrl.wb_src = WB_LINK;
				if (rt != 5'd1)	// Anything but BGEZ links
				begin
					ctrl.reg_dst = DST_RA;
					ctrl.reg_we = 1'b1;
				end
			end
			6'b100011, 6'b100000:	// LW, LB
			begin
				ctrl.wb_src = WB_MEM;
				ctrl.alu_imm = 1'b1;	// Base plus offset
				ctrl.reg_we = 1'b1;
				ctrl.mem_byte = ~opcode[0];	// LB has bit 0 clear
			end
			6'b101011, 6'b101000:	// SW, SB
			begin
				ctrl.alu_imm = 1'b1;
				ctrl.mem_we = 1'b1;
				ctrl.mem_byte = ~opcode[0];	// SB has bit 0 clear
			end
			6'b000010:	// J
			begin
				ctrl.pc_src = PC_JUMP;
			end
			6'b000011:	// JAL
			begin
				ctrl.pc_src = PC_JUMP;
				ctrl.reg_dst = DST_RA;	// Return address to $ra
				ctrl.wb_src = WB_LINK;
				ctrl.reg_we = 1'b1;
			end
			default:
			begin
				ctrl.pc_src = PC_SEQ;	// Unknown opcode, keep defaults
			end
		endcase
	end

	always_comb
	begin
		case (ctrl.reg_dst)
			DST_RD: wr_idx = rd;
			DST_RA: wr_idx = REG_RA;
			default: wr_idx = rt;
		endcase
	end

endmodule

/* decode/register_file.sv */
`timescale 1ns/1ns

module register_file
	import mips_pkg::*;
(
	input logic clk,	// Core clock
	input logic reset,	// Clears every register
	input reg_idx_t rs_idx,	// First read port
	input reg_idx_t rt_idx,	// Second read port
	input logic we,	// Write enable
	input reg_idx_t wr_idx,	// Write port index
	input word_t wr_data,	// Write port data
	output word_t rs_value,	// First read data
	output word_t rt_value	// Second read data
);

	word_t regs [32];	// Register array

	// Register 0 always reads as zero
	assign rs_value = (rs_idx == '0) ? '0 : regs[rs_idx];
	assign rt_value = (rt_idx == '0) ? '0 : regs[rt_idx];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && (wr_idx != '0))	// Drop writes to register 0
		begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

/* execute/alu.sv */
`timescale 1ns/1ns

module alu
	import mips_pkg::*;
(
	input alu_op_t op,	// Operation from decode
	input funct_t funct,	// R-type function field
	input word_t a,	// rs
	input word_t b,	// rt or immediate
	output word_t result,	// Operation result
	output logic zero	// Result is zero
);

	always_comb
	begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_LUI: result = {b[15:0], 16'b0};	// Immediate to upper half
			ALU_GEZ: result = {31'b0, a[31]};	// Zero when a is not negative
			ALU_FUNCT:
			begin
				case (funct)
					6'h20, 6'h21: result = a + b;	// ADD, ADDU
					6'h22, 6'h23: result = a - b;	// SUB, SUBU
					6'h24: result = a & b;	// AND
					6'h25: result = a | b;	// OR
					6'h26: result = a ^ b;	// XOR
					6'h27: result = ~(a | b);	// NOR
					6'h2a: result = {31'b0, $signed(a) < $signed(b)};	// SLT
					default: result = '0;	// Unsupported funct
				endcase
			end
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);	// Feeds branch decision

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage
	import mips_pkg::*;
(
	input word_t instr,	// Current instruction
	input ctrl_t ctrl,	// Decoded control
	input word_t rs_value,	// Operand a
	input word_t rt_value,	// Register operand b
	input word_t pc_plus1,	// Base for branch target
	output word_t alu_result,	// ALU output, also data address
	output logic branch_taken,	// Branch condition met
	output word_t branch_target	// PC+1+offset
);

	word_t imm_sext;	// imm16 sign extended
	word_t imm_ext;	// imm16 as the instruction wants it
	word_t alu_b;	// Second ALU operand
	logic alu_zero;	// ALU zero flag

	assign imm_sext = {{16{instr[15]}}, instr[15:0]};
	assign imm_ext = ctrl.imm_signed ? imm_sext : {16'b0, instr[15:0]};	// Logic ops zero extend
	assign alu_b = ctrl.alu_imm ? imm_ext : rt_value;

	alu u_alu (
		.op(ctrl.alu_op),
		.funct(instr[5:0]),
		.a(rs_value),
		.b(alu_b),
		.result(alu_result),
		.zero(alu_zero)
	);

	// BEQ and BGEZ want zero set, BNE wants it clear
	assign branch_taken = (alu_zero == ctrl.branch_eq);
	assign branch_target = pc_plus1 + imm_sext;	// Word offset

endmodule

/* fetch/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage
	import mips_pkg::*;
(
	input logic clk,	// Core clock
	input logic reset,	// Synchronous reset
	input pc_src_t pc_src,	// Next PC source from decode
	input logic branch_taken,	// Branch condition met
	input word_t branch_target,	// PC+1+offset
	input word_t rs_value,	// Target for JR/JALR
	input jump_t jump_field,	// Target field for J/JAL
	output word_t pc,	// Address of current instruction
	output word_t pc_plus1	// Address of next instruction
);

	word_t next_pc;	// Value loaded at the next edge

	assign pc_plus1 = pc + 32'd1;	// Word counter steps by one

	always_comb
	begin
		case (pc_src)
			PC_BRANCH:
			begin
				if (branch_taken)
					next_pc = branch_target;	// Taken branch
				else
					next_pc = pc_plus1;	// Fall through
			end
			PC_JUMP:
			begin
				next_pc = {pc_plus1[31:26], jump_field};	// Keep region bits of PC+1
			end
			PC_REG:
			begin
				next_pc = rs_value;	// Register jump
			end
			default:
			begin
				next_pc = pc_plus1;	// Sequential
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0;	// Start at word 0
		else
			pc <= next_pc;
	end

endmodule

/* filelist.f */
common/mips_pkg.sv
fetch/fetch_stage.sv
decode/control_unit.sv
decode/register_file.sv
execute/alu.sv
execute/execute_stage.sv
rtl/mem_stage.sv
rtl/mips_core.sv
sim/tb_mips_core.sv

/* rtl/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage
	import mips_pkg::*;
#(
	parameter int DMEM_WORDS = 256	// Data memory depth in words
)
(
	input logic clk,	// Core clock
	input ctrl_t ctrl,	// Decoded control
	input word_t alu_result,	// Byte address or ALU value
	input word_t store_data,	// rt value for stores
	input word_t pc_plus1,	// Return address for links
	output word_t wb_data	// Data for the register file
);

	localparam int AW = $clog2(DMEM_WORDS);	// Word index width

	word_t mem [DMEM_WORDS];	// Data memory
	logic [AW-1:0] word_idx;	// Word select above bit 1
	logic [1:0] lane;	// Byte lane
	word_t rd_word;	// Addressed word
	logic [7:0] rd_byte;	// Addressed byte
	word_t load_data;	// Word or sign-extended byte

	assign word_idx = alu_result[AW+1:2];
	assign lane = alu_result[1:0];	// Ignored in word mode
	assign rd_word = mem[word_idx];
	assign rd_byte = rd_word[lane*8 +: 8];
	assign load_data = ctrl.mem_byte ? {{24{rd_byte[7]}}, rd_byte} : rd_word;

	always_ff @(posedge clk)
	begin
		if (ctrl.mem_we)
		begin
			if (ctrl.mem_byte)
				mem[word_idx][lane*8 +: 8] <= store_data[7:0];	// Only the addressed lane
			else
				mem[word_idx] <= store_data;
		end
	end

	always_comb
	begin
		case (ctrl.wb_src)
			WB_MEM: wb_data = load_data;
			WB_LINK: wb_data = pc_plus1;	// Return address
			default: wb_data = alu_result;
		endcase
	end

endmodule

/* rtl/mips_core.sv */
`timescale 1ns/1ns

module mips_core
	import mips_pkg::*;
#(
	parameter int DMEM_WORDS = 256	// Data memory depth in words
)
(
	input logic clk,	// Core clock
	input logic reset,	// Synchronous reset
	output word_t imem_addr,	// Word address of instruction
	input word_t imem_data,	// Instruction word
	output logic rf_we,	// Register write this cycle
	output reg_idx_t rf_addr,	// Register being written
	output word_t rf_data,	// Data being written
	output logic dm_we,	// Store this cycle
	output word_t dm_addr,	// Store byte address
	output word_t dm_data	// Store data from rt
);

	word_t pc;	// Current PC
	word_t pc_plus1;	// Next sequential PC
	ctrl_t ctrl;	// Decoded control
	reg_idx_t wr_idx;	// Destination register
	word_t rs_value;	// rs read data
	word_t rt_value;	// rt read data
	word_t alu_result;	// ALU output
	logic branch_taken;	// Branch decision
	word_t branch_target;	// Branch destination
	word_t wb_data;	// Writeback data

	fetch_stage u_fetch (
		.clk(clk),
		.reset(reset),
		.pc_src(ctrl.pc_src),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.rs_value(rs_value),
		.jump_field(imem_data[25:0]),
		.pc(pc),
		.pc_plus1(pc_plus1)
	);

	control_unit u_control (
		.instr(imem_data),
		.ctrl(ctrl),
		.wr_idx(wr_idx)
	);

	register_file u_regs (
		.clk(clk),
		.reset(reset),
		.rs_idx(imem_data[25:21]),
		.rt_idx(imem_data[20:16]),
		.we(ctrl.reg_we),
		.wr_idx(wr_idx),
		.wr_data(wb_data),
		.rs_value(rs_value),
		.rt_value(rt_value)
	);

	execute_stage u_execute (
		.instr(imem_data),
		.ctrl(ctrl),
		.rs_value(rs_value),
		.rt_value(rt_value),
		.pc_plus1(pc_plus1),
		.alu_result(alu_result),
		.branch_taken(branch_taken),
		.branch_target(branch_target)
	);

	mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
		.clk(clk),
		.ctrl(ctrl),
		.alu_result(alu_result),
		.store_data(rt_value),
		.pc_plus1(pc_plus1),
		.wb_data(wb_data)
	);

	assign imem_addr = pc;

	// Retirement trace committed at the next edge
	assign rf_we = ctrl.reg_we;
	assign rf_addr = wr_idx;
	assign rf_data = wb_data;
	assign dm_we = ctrl.mem_we;
	assign dm_addr = alu_result;
	assign dm_data = rt_value;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the MIPS core testbench with Verilator
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --top-module tb_mips_core -f filelist.f -o tb_mips_core \
	> build.log 2>&1 &&
./obj_dir/tb_mips_core > sim.log 2>&1 ||
{ cat build.log; echo "Build or run failed"; exit 1; }
cat sim.log
grep -q "^RESULT: PASS$" sim.log || exit 1

/* sim/tb_mips_core.sv */
`timescale 1ns/1ns

module tb_mips_core
	import mips_pkg::*;
;

	localparam int NUM_TESTS = 5;	// Directed tests in the run
	localparam int TOTAL_STEPS = 56;	// Instructions stepped over all tests
	localparam int RESET_CYCLES = 16;	// Reset length per test
	localparam int CYCLE_LIMIT = 2 * TOTAL_STEPS + NUM_TESTS * RESET_CYCLES;

	logic clk;
	logic reset;
	word_t imem_addr;
	word_t imem_data;
	logic rf_we;
	reg_idx_t rf_addr;
	word_t rf_data;
	logic dm_we;
	word_t dm_addr;
	word_t dm_data;

	word_t imem [64];	// Instruction memory model
	logic [5:0] plen;	// Next free program slot
	word_t mreg [32];	// Reference register file
	word_t mdm [256];	// Reference data memory in words
	word_t mpc;	// Reference PC
	word_t cur_pc;	// Address of the instruction being checked

	logic exp_rf_we;	// Expected trace of the current instruction
	reg_idx_t exp_rf_addr;
	word_t exp_rf_data;
	logic exp_dm_we;
	word_t exp_dm_addr;
	word_t exp_dm_data;
	word_t exp_pc;	// Expected address of the next instruction

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;

	mips_core #(.DMEM_WORDS(256)) DUT (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.rf_we(rf_we),
		.rf_addr(rf_addr),
		.rf_data(rf_data),
		.dm_we(dm_we),
		.dm_addr(dm_addr),
		.dm_data(dm_data)
	);

	always #2 clk = ~clk;	// 4 ns period

	always @(posedge clk)
	begin
		#1;
		imem_data = imem_read(imem_addr);	// Word follows the new PC
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic word_t imem_read(input word_t addr);
		if (addr < 32'd64)
			return imem[addr[5:0]];
		return '0;	// Outside the program reads as a no-op
	endfunction

	function automatic word_t rtype_word(input reg_idx_t rs, input reg_idx_t rt,
		input reg_idx_t rd, input funct_t fn);
		return {6'b000000, rs, rt, rd, 5'b00000, fn};
	endfunction

	function automatic word_t itype_word(input funct_t op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_word(input funct_t op, input jump_t target);
		return {op, target};
	endfunction

	function automatic word_t rtype_result(input funct_t fn, input word_t a, input word_t b);
		case (fn)
			6'h20, 6'h21: return a + b;
			6'h22, 6'h23: return a - b;
			6'h24: return a & b;
			6'h25: return a | b;
			6'h26: return a ^ b;
			6'h27: return ~(a | b);
			6'h2a: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;	// Signed compare
			default: return '0;
		endcase
	endfunction

	task automatic clear_program();
		imem = '{default: '0};
		plen = '0;
	endtask

	task automatic place(input logic [5:0] idx, input word_t w);
		imem[idx] = w;
	endtask

	task automatic emit(input word_t w);
		place(plen, w);
		plen = plen + 6'd1;	// Straight-line programs
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		mpc = '0;
		mreg = '{default: '0};	// Registers cleared, data memory kept
	endtask

	task automatic set_write(input reg_idx_t idx, input word_t data);
		exp_rf_we = 1'b1;
		exp_rf_addr = idx;
		exp_rf_data = data;
	endtask

	// Instruction-level reference model giving the expected trace and next state
	task automatic model_step(input word_t instr);
		funct_t op;
		funct_t fn;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		word_t a;
		word_t b;
		word_t simm;
		word_t zimm;
		word_t pc1;
		word_t addr;
		logic [4:0] sh;
		logic [7:0] byte_v;
		op = instr[31:26];
		fn = instr[5:0];
		rs = instr[25:21];
		rt = instr[20:16];
		rd = instr[15:11];
		a = mreg[rs];
		b = mreg[rt];
		simm = {{16{instr[15]}}, instr[15:0]};
		zimm = {16'h0000, instr[15:0]};
		pc1 = mpc + 32'd1;
		addr = a + simm;	// Byte address for loads and stores
		sh = {addr[1:0], 3'b000};	// Bit offset of the byte lane
		byte_v = 8'(mdm[addr[9:2]] >> sh);
		exp_rf_we = 1'b0;
		exp_rf_addr = '0;
		exp_rf_data = '0;
		exp_dm_we = 1'b0;
		exp_dm_addr = addr;
		exp_dm_data = b;
		exp_pc = pc1;
		case (op)
			6'h00:
			begin
				if (fn == 6'h08)
					exp_pc = a;	// JR
				else if (fn == 6'h09)
				begin
					exp_pc = a;	// JALR
					set_write(rd, pc1);
				end
				else if (fn >= 6'h20)
					set_write(rd, rtype_result(fn, a, b));
			end
			6'h08, 6'h09: set_write(rt, a + simm);
			6'h0c: set_write(rt, a & zimm);
			6'h0d: set_write(rt, a | zimm);
			6'h0e: set_write(rt, a ^ zimm);
			6'h0f: set_write(rt, {instr[15:0], 16'h0000});
			6'h04: if (a == b) exp_pc = pc1 + simm;
			6'h05: if (a != b) exp_pc = pc1 + simm;
			6'h01:
			begin
				if (!a[31])
					exp_pc = pc1 + simm;	// rs not negative
				if (rt != 5'd1)
					set_write(REG_RA, pc1);	// BGEZAL links even when not taken
			end
			6'h23: set_write(rt, mdm[addr[9:2]]);
			6'h20: set_write(rt, {{24{byte_v[7]}}, byte_v});
			6'h2b:
			begin
				exp_dm_we = 1'b1;
				mdm[addr[9:2]] = b;
			end
			6'h28:
			begin
				exp_dm_we = 1'b1;
				mdm[addr[9:2]] = (mdm[addr[9:2]] & ~(32'hff << sh)) | ({24'h0, b[7:0]} << sh);
			end
			6'h02: exp_pc = {pc1[31:26], instr[25:0]};
			6'h03:
			begin
				exp_pc = {pc1[31:26], instr[25:0]};
				set_write(REG_RA, pc1);
			end
			default: ;	// Unknown opcode does nothing
		endcase
		if (exp_rf_we && (exp_rf_addr != 5'd0))
			mreg[exp_rf_addr] = exp_rf_data;
		mpc = exp_pc;
	endtask

	task automatic compare(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("[ERROR] %s: expected 0x%h, got 0x%h (pc 0x%h)", name, exp, got, cur_pc);
			errors++;
		end
	endtask

	task automatic run_steps(input int n);
		word_t instr;
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);	// Combinational trace is settled here
			instr = imem_read(mpc);
			cur_pc = mpc;
			compare("imem_addr", imem_addr, mpc);
			model_step(instr);
			compare("rf_we", {31'b0, rf_we}, {31'b0, exp_rf_we});
			if (exp_rf_we)
			begin
				compare("rf_addr", {27'b0, rf_addr}, {27'b0, exp_rf_addr});
				compare("rf_data", rf_data, exp_rf_data);
			end
			compare("dm_we", {31'b0, dm_we}, {31'b0, exp_dm_we});
			if (exp_dm_we)
			begin
				compare("dm_addr", dm_addr, exp_dm_addr);
				compare("dm_data", dm_data, exp_dm_data);
			end
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("%-14s done, %0d errors", name, errors - err_before);
	endtask

	task automatic idle_after_reset();
		int err_before = errors;
		clear_program();
		emit(32'h0000_0000);	// Funct 0 R-type
		emit(rtype_word(1, 2, 3, 6'h18));	// Multiply group writes nothing
		emit(32'hfc00_0000);	// Unknown opcode
		emit(32'h0000_0000);
		apply_reset();
		run_steps(4);
		report_test("reset_idle", err_before);
	endtask

	task automatic arith_logic();
		int err_before = errors;
		logic [15:0] imm [6];
		for (int i = 0; i < 6; i++)
			imm[i] = 16'($urandom);
		imm[1][15] = 1'b1;	// Shows zero extension of ORI
		imm[5][15] = 1'b1;	// Negative ADDIU
		clear_program();
		emit(itype_word(6'h08, 0, 1, imm[0]));	// ADDI
		emit(itype_word(6'h0d, 0, 2, imm[1]));	// ORI
		emit(itype_word(6'h0f, 0, 3, imm[2]));	// LUI
		emit(itype_word(6'h0e, 1, 4, imm[3]));	// XORI
		emit(itype_word(6'h0c, 1, 5, imm[4]));	// ANDI
		emit(itype_word(6'h09, 0, 6, imm[5]));	// ADDIU
		emit(rtype_word(1, 2, 7, 6'h20));	// ADD
		emit(rtype_word(1, 6, 8, 6'h22));	// SUB
		emit(rtype_word(4, 5, 9, 6'h24));	// AND
		emit(rtype_word(3, 2, 10, 6'h25));	// OR
		emit(rtype_word(1, 3, 11, 6'h26));	// XOR
		emit(rtype_word(1, 2, 12, 6'h27));	// NOR
		emit(rtype_word(6, 2, 13, 6'h2a));	// SLT with the negative operand first
		emit(rtype_word(2, 6, 14, 6'h2a));	// SLT with the negative operand second
		emit(itype_word(6'h08, 1, 0, 16'h0005));	// Write to register 0
		emit(rtype_word(0, 1, 15, 6'h21));	// Register 0 still reads zero
		apply_reset();
		run_steps(16);
		report_test("arith_logic", err_before);
	endtask

	task automatic loads_stores();
		int err_before = errors;
		logic [15:0] hi;
		logic [15:0] lo;
		logic [7:0] neg_byte;
		hi = 16'($urandom);
		lo = 16'($urandom);
		neg_byte = 8'($urandom) | 8'h80;	// Top bit set for sign extension
		clear_program();
		emit(itype_word(6'h08, 0, 1, 16'h0040));	// Base address
		emit(itype_word(6'h0f, 0, 2, hi));
		emit(itype_word(6'h0d, 2, 2, lo));
		emit(itype_word(6'h2b, 1, 2, 16'h0000));	// SW to 0x40
		emit(itype_word(6'h2b, 1, 2, 16'h0004));	// SW to 0x44
		emit(itype_word(6'h08, 0, 3, {8'h00, neg_byte}));
		emit(itype_word(6'h28, 1, 3, 16'h0005));	// SB into lane 1 of 0x44
		emit(itype_word(6'h23, 1, 4, 16'h0000));	// LW 0x40
		emit(itype_word(6'h23, 1, 5, 16'h0004));	// LW merged word
		emit(itype_word(6'h20, 1, 6, 16'h0005));	// LB negative byte
		emit(itype_word(6'h20, 1, 7, 16'h0006));	// LB lane 2
		emit(itype_word(6'h23, 1, 8, 16'h0007));	// LW ignores low bits
		apply_reset();
		run_steps(12);
		report_test("loads_stores", err_before);
	endtask

	task automatic branches();
		int err_before = errors;
		clear_program();
		place(0, itype_word(6'h08, 0, 1, 16'd5));
		place(1, itype_word(6'h08, 0, 2, 16'd5));
		place(2, itype_word(6'h08, 0, 3, 16'hfffd));	// r3 = -3
		place(3, itype_word(6'h04, 1, 2, 16'd2));	// BEQ taken
		place(4, itype_word(6'h08, 0, 10, 16'd1));
		place(5, itype_word(6'h08, 0, 10, 16'd2));
		place(6, itype_word(6'h05, 1, 2, 16'd5));	// BNE not taken
		place(7, itype_word(6'h05, 1, 3, 16'd1));	// BNE taken
		place(8, itype_word(6'h08, 0, 10, 16'd3));
		place(9, itype_word(6'h04, 1, 3, 16'd4));	// BEQ not taken
		place(10, itype_word(6'h01, 1, 1, 16'd1));	// BGEZ on positive
		place(11, itype_word(6'h08, 0, 10, 16'd4));
		place(12, itype_word(6'h01, 3, 1, 16'd3));	// BGEZ on negative
		place(13, itype_word(6'h04, 0, 0, 16'd2));
		place(14, itype_word(6'h08, 0, 11, 16'd7));
		place(16, itype_word(6'h05, 0, 1, 16'hfffd));	// Backward branch
		apply_reset();
		run_steps(13);
		report_test("branches", err_before);
	endtask

	task automatic jumps_links();
		int err_before = errors;
		clear_program();
		place(0, itype_word(6'h08, 0, 1, 16'd20));
		place(1, jump_word(6'h03, 26'd10));	// JAL
		place(10, itype_word(6'h08, 0, 2, 16'd30));
		place(11, rtype_word(2, 0, 5, 6'h09));	// JALR into r5
		place(30, itype_word(6'h01, 0, 5'h11, 16'd2));	// BGEZAL taken
		place(33, rtype_word(1, 0, 0, 6'h08));	// JR
		place(20, jump_word(6'h02, 26'd40));	// J
		place(40, itype_word(6'h08, 0, 3, 16'hffff));
		place(41, itype_word(6'h01, 3, 5'h11, 16'd5));	// BGEZAL not taken
		place(42, jump_word(6'h02, 26'd0));	// Back to the start
		apply_reset();
		run_steps(11);
		report_test("jumps_links", err_before);
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		imem_data = '0;
		void'($urandom(52114));
		idle_after_reset();
		arith_logic();
		loads_stores();
		branches();
		jumps_links();
		$display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
